// File: sources.f
sh_pkg.sv
sh_decode.sv
sh_regfile.sv
sh_execute.sv
sh_result.sv
sh_core.sv
sh_core_properties.sv
tb_sh_core.sv

// File: Bender.yml
package:
  name: sh_core

sources:
  - files:
      - sh_pkg.sv
      - sh_decode.sv
      - sh_regfile.sv
      - sh_execute.sv
      - sh_result.sv
      - sh_core.sv
  - target: test
    files:
      - sh_core_properties.sv
      - tb_sh_core.sv

// File: tb_sh_core.sv
module tb_sh_core import sh_pkg::*; ();

	localparam int n_reset   = 8;
	localparam int n_imm     = 24;
	localparam int n_alu     = 48;
	localparam int n_flags   = 48;
	localparam int n_chain   = 40;
	localparam int n_illegal = 48;
	localparam int n_total   = n_reset + n_imm + n_alu + n_flags + n_chain + n_illegal;
	localparam int cycle_limit = 16 + 4 * n_total + 50;
	// Two-cycle retire latency plus margin
	localparam int n_drain   = 4;

	logic        CLK;
	logic        RST_N;
	logic        instr_valid;
	logic [15:0] instr;
	logic        wb_valid;
	logic        wb_write;
	logic [3:0]  wb_reg;
	logic [31:0] wb_data;
	logic        t_flag;

	integer      seed;
	int          err_cnt;
	int          chk_cnt;
	int          test_cnt;
	int          cycle_cnt;

	// Reference state and expected retire records {write, reg, data, T}
	logic [31:0] m_regs [16];
	logic [31:0] m_data;
	logic        m_t;
	logic [37:0] exp_q [$];
	logic [37:0] rec;

	sh_core UUT (
		.CLK(CLK), .RST_N(RST_N), .instr_valid(instr_valid), .instr(instr),
		.wb_valid(wb_valid), .wb_write(wb_write), .wb_reg(wb_reg),
		.wb_data(wb_data), .t_flag(t_flag)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("Run stopped after %0d cycles, the DUT stopped retiring", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	function automatic int rand_range(input int lo, input int hi);
		int unsigned r;
		r = $random(seed);
		return lo + int'(r % (hi - lo + 1));
	endfunction

	// ********************
	// Instruction encoding
	// ********************
	function automatic logic [15:0] make_word(input int sel, input logic [3:0] rn,
						  input logic [3:0] rm, input logic [7:0] imm);
		case (sel)
			0:       return {op_mov_imm, rn, imm};
			1:       return {op_add_imm, rn, imm};
			2:       return {op_arith, rn, rm, fn_add};
			3:       return {op_arith, rn, rm, fn_sub};
			4:       return {op_arith, rn, rm, fn_addc};
			5:       return {op_logic, rn, rm, fn_and};
			6:       return {op_logic, rn, rm, fn_or};
			7:       return {op_logic, rn, rm, fn_xor};
			8:       return {op_mov_reg, rn, rm, mov_reg_fn};
			9:       return {op_shift, rn, 4'h0, fn_shlr};
			10:      return {op_shift, rn, 4'h0, fn_shll};
			11:      return {op_shift, rn, 4'h0, fn_rotl};
			12:      return {op_shift, rn, 4'h0, fn_rotr};
			13:      return {op_arith, rn, rm, fn_cmp_eq};
			14:      return {op_arith, rn, rm, fn_cmp_gt};
			default: return {op_logic, rn, rm, fn_tst};
		endcase
	endfunction

	// ********************
	// Reference model
	// ********************
	task automatic model_exec(input logic [15:0] w);
		logic [3:0]  op;
		logic [3:0]  rn;
		logic [3:0]  rm;
		logic [3:0]  fn;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic [32:0] sum;
		logic        wr;
		op  = w[15:12];
		rn  = w[11:8];
		rm  = w[7:4];
		fn  = w[3:0];
		a   = m_regs[rn];
		b   = m_regs[rm];
		imm = {{24{w[7]}}, w[7:0]};
		res = '0;
		wr  = 1'b1;
		case (op)
			op_mov_imm: res = imm;
			op_add_imm: res = a + imm;
			op_arith: begin
				case (fn)
					fn_add:    res = a + b;
					fn_sub:    res = a - b;
					fn_cmp_eq: m_t = (a == b);
					fn_cmp_gt: m_t = ($signed(a) > $signed(b));
					fn_addc: begin
						sum = {1'b0, a} + {1'b0, b} + {32'd0, m_t};
						res = sum[31:0];
						m_t = sum[32];
					end
					default: ;
				endcase
				wr = (fn == fn_add) || (fn == fn_sub) || (fn == fn_addc);
			end
			op_logic: begin
				case (fn)
					fn_and:  res = a & b;
					fn_or:   res = a | b;
					fn_xor:  res = a ^ b;
					fn_tst:  m_t = ((a & b) == 32'd0);
					default: ;
				endcase
				wr = (fn == fn_and) || (fn == fn_or) || (fn == fn_xor);
			end
			op_shift: begin
				wr = (rm == 4'h0);
				if (wr && fn == fn_shll) begin
					res = {a[30:0], 1'b0};
					m_t = a[31];
				end else if (wr && fn == fn_shlr) begin
					res = {1'b0, a[31:1]};
					m_t = a[0];
				end else if (wr && fn == fn_rotl) begin
					res = {a[30:0], a[31]};
					m_t = a[31];
				end else if (wr && fn == fn_rotr) begin
					res = {a[0], a[31:1]};
					m_t = a[0];
				end else begin
					wr = 1'b0;
				end
			end
			op_mov_reg: begin
				wr  = (fn == mov_reg_fn);
				res = b;
			end
			default: wr = 1'b0;
		endcase
		if (wr) begin
			m_regs[rn] = res;
			m_data     = res;
		end
		exp_q.push_back({wr, rn, m_data, m_t});
	endtask

	task automatic send_instr(input logic [15:0] w, input int gap);
		@(posedge CLK);
		instr_valid <= 1'b1;
		instr       <= w;
		model_exec(w);
		repeat (gap) begin
			@(posedge CLK);
			instr_valid <= 1'b0;
		end
	endtask

	// Mode 0 random gaps, mode 1 dependent chain, mode 2 unused words mixed in
	task automatic run_test(input string name, input int count, input int lo,
				input int hi, input int mode);
		int          errs_before;
		int          sel;
		int          gap;
		logic [3:0]  rn;
		logic [3:0]  rm;
		logic [3:0]  prev;
		logic [15:0] w;
		errs_before = err_cnt;
		prev        = 4'(rand_range(0, 15));
		for (int i = 0; i < count; i++) begin
			sel = rand_range(lo, hi);
			rn  = 4'(rand_range(0, 15));
			rm  = 4'(rand_range(0, 15));
			gap = rand_range(0, 3);
			if (mode == 1) begin
				gap = 0;
				rm  = prev;
				if ((sel >= 9 && sel <= 12) || rand_range(0, 1) == 1) begin
					rn = prev;
				end
			end
			w = make_word(sel, rn, rm, 8'(rand_range(0, 255)));
			if (mode == 2 && rand_range(0, 1) == 1) begin
				w     = 16'($random(seed));
				w[15] = 1'b1;
				if (w[15:12] == op_mov_imm) begin
					w[12] = 1'b1;
				end
			end
			send_instr(w, gap);
			prev = w[11:8];
		end
		@(posedge CLK);
		instr_valid <= 1'b0;
		for (int i = 0; i < n_drain && exp_q.size() != 0; i++) begin
			@(posedge CLK);
		end
		test_cnt++;
		$display("Test %-8s %0d instructions, %0d errors", name, count, err_cnt - errs_before);
	endtask

	// Retire port sampled mid-cycle
	always @(negedge CLK) begin
		if (RST_N && wb_valid) begin
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("Instruction retired at %0t with none outstanding", $time);
			end else begin
				rec = exp_q.pop_front();
				check_value("wb_write", {31'd0, rec[37]}, {31'd0, wb_write});
				check_value("wb_reg", {28'd0, rec[36:33]}, {28'd0, wb_reg});
				check_value("wb_data", rec[32:1], wb_data);
				check_value("t_flag", {31'd0, rec[0]}, {31'd0, t_flag});
			end
		end
	end

	initial begin
		RST_N       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		seed        = 32'h7add;
		m_data      = '0;
		m_t         = 1'b0;
		for (int i = 0; i < 16; i++) begin
			m_regs[i] = '0;
		end
		repeat (16) @(posedge CLK);
		RST_N <= 1'b1;
		@(negedge CLK);
		check_value("wb_valid", 32'd0, {31'd0, wb_valid});
		check_value("wb_write", 32'd0, {31'd0, wb_write});
		check_value("t_flag", 32'd0, {31'd0, t_flag});
		run_test("reset", n_reset, 8, 8, 0);
		run_test("imm", n_imm, 0, 1, 0);
		run_test("alu", n_alu, 2, 9, 0);
		run_test("flags", n_flags, 9, 15, 0);
		run_test("chain", n_chain, 2, 15, 1);
		run_test("illegal", n_illegal, 0, 15, 2);
		if (exp_q.size() != 0) begin
			err_cnt++;
			$display("%0d expected instructions never retired", exp_q.size());
		end
		$display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: sh_core_properties.sv
module sh_core_properties (
	input logic CLK,
	input logic RST_N,
	input logic instr_valid,
	input logic wb_valid,
	input logic wb_write
);

	// ********************
	// Retire timing
	// ********************
	property strobe_retires;
		@(posedge CLK) disable iff (!RST_N) instr_valid |-> ##2 wb_valid;
	endproperty

	property retire_has_strobe;
		@(posedge CLK) disable iff (!RST_N) wb_valid |-> $past(instr_valid, 2);
	endproperty

	property write_needs_valid;
		@(posedge CLK) disable iff (!RST_N) wb_write |-> wb_valid;
	endproperty

	// Reset keeps the retire port quiet
	property quiet_in_reset;
		@(posedge CLK) !RST_N |-> !wb_valid;
	endproperty

	a_strobe_retires: assert property (strobe_retires)
		else $error("wb_valid missing two cycles after a strobe");
	a_retire_has_strobe: assert property (retire_has_strobe)
		else $error("wb_valid without a strobe two cycles earlier");
	a_write_needs_valid: assert property (write_needs_valid)
		else $error("wb_write high while wb_valid is low");
	a_quiet_in_reset: assert property (quiet_in_reset)
		else $error("wb_valid high during reset");

endmodule

bind sh_core sh_core_properties props (
	.CLK(CLK), .RST_N(RST_N), .instr_valid(instr_valid),
	.wb_valid(wb_valid), .wb_write(wb_write)
);

// File: sh_core.sv
module sh_core import sh_pkg::*; (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               instr_valid,
	input  logic [instr_w-1:0] instr,
	output logic               wb_valid,
	output logic               wb_write,
	output logic [reg_n_w-1:0] wb_reg,
	output logic [data_w-1:0]  wb_data,
	output logic               t_flag
);

	// Decode to execute
	logic               dec_valid;
	alu_op_t            dec_op;
	logic [reg_n_w-1:0] dec_rn;
	logic [reg_n_w-1:0] dec_rm;
	logic               dec_use_imm;
	logic [data_w-1:0]  dec_imm;
	logic               dec_write;

	logic [data_w-1:0]  ra_q;
	logic [data_w-1:0]  rb_q;

	// Execute to result
	logic               ex_valid;
	logic               ex_write;
	logic [reg_n_w-1:0] ex_rn;
	logic [data_w-1:0]  ex_data;
	logic               ex_t;

	// Register write
	logic               rf_we;
	logic [reg_n_w-1:0] rf_wn;
	logic [data_w-1:0]  rf_wd;

	sh_decode decode (
		.CLK(CLK), .RST_N(RST_N), .instr_valid(instr_valid), .instr(instr),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rn(dec_rn), .dec_rm(dec_rm),
		.dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .dec_write(dec_write)
	);

	sh_regfile regfile (
		.CLK(CLK), .RST_N(RST_N), .ra_n(dec_rn), .rb_n(dec_rm),
		.we(rf_we), .wn(rf_wn), .wd(rf_wd), .ra_q(ra_q), .rb_q(rb_q)
	);

	sh_execute execute (
		.CLK(CLK), .RST_N(RST_N), .dec_valid(dec_valid), .dec_op(dec_op),
		.dec_rn(dec_rn), .dec_rm(dec_rm), .dec_use_imm(dec_use_imm), .dec_imm(dec_imm),
		.dec_write(dec_write), .ra_q(ra_q), .rb_q(rb_q), .ex_valid(ex_valid),
		.ex_write(ex_write), .ex_rn(ex_rn), .ex_data(ex_data), .ex_t(ex_t)
	);

	sh_result result (
		.ex_valid(ex_valid), .ex_write(ex_write), .ex_rn(ex_rn), .ex_data(ex_data),
		.ex_t(ex_t), .rf_we(rf_we), .rf_wn(rf_wn), .rf_wd(rf_wd),
		.wb_valid(wb_valid), .wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data),
		.t_flag(t_flag)
	);

endmodule

// File: sh_result.sv
module sh_result import sh_pkg::*; (
	input  logic               ex_valid,
	input  logic               ex_write,
	input  logic [reg_n_w-1:0] ex_rn,
	input  logic [data_w-1:0]  ex_data,
	input  logic               ex_t,
	output logic               rf_we,
	output logic [reg_n_w-1:0] rf_wn,
	output logic [data_w-1:0]  rf_wd,
	output logic               wb_valid,
	output logic               wb_write,
	output logic [reg_n_w-1:0] wb_reg,
	output logic [data_w-1:0]  wb_data,
	output logic               t_flag
);

	logic commit;

	// ********************
	// Commit point
	// ********************
	assign commit = ex_valid & ex_write;

	assign rf_we = commit;
	assign rf_wn = ex_rn;
	assign rf_wd = ex_data;

	// Retire record
	assign wb_valid = ex_valid;
	assign wb_write = commit;
	assign wb_reg   = ex_rn;
	assign wb_data  = ex_data;
	assign t_flag   = ex_t;

endmodule

// File: sh_execute.sv
module sh_execute import sh_pkg::*; (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               dec_valid,
	input  alu_op_t            dec_op,
	input  logic [reg_n_w-1:0] dec_rn,
	input  logic [reg_n_w-1:0] dec_rm,
	input  logic               dec_use_imm,
	input  logic [data_w-1:0]  dec_imm,
	input  logic               dec_write,
	input  logic [data_w-1:0]  ra_q,
	input  logic [data_w-1:0]  rb_q,
	output logic               ex_valid,
	output logic               ex_write,
	output logic [reg_n_w-1:0] ex_rn,
	output logic [data_w-1:0]  ex_data,
	output logic               ex_t
);

	logic              fwd_a;
	logic              fwd_b;
	logic [data_w-1:0] op_a;
	logic [data_w-1:0] reg_b;
	logic [data_w-1:0] op_b;
	logic              t_cur;
	logic [data_w-1:0] add_b;
	logic              add_cin;
	logic [data_w:0]   add_sum;
	logic [data_w-1:0] alu_res;
	logic              t_next;

	// ********************
	// Forwarding
	// ********************
	assign fwd_a = ex_valid & ex_write & (ex_rn == dec_rn);
	assign fwd_b = ex_valid & ex_write & (ex_rn == dec_rm);

	assign op_a  = fwd_a ? ex_data : ra_q;
	assign reg_b = fwd_b ? ex_data : rb_q;
	assign op_b  = dec_use_imm ? dec_imm : reg_b;

	// Result register always holds the newest T
	assign t_cur = ex_t;

	// ********************
	// ALU
	// ********************
	assign add_b   = (dec_op == alu_sub) ? ~op_b : op_b;
	assign add_cin = (dec_op == alu_sub) | ((dec_op == alu_addc) & t_cur);
	assign add_sum = {1'b0, op_a} + {1'b0, add_b} + {{data_w{1'b0}}, add_cin};

	always_comb begin
		alu_res = op_b;
		t_next  = t_cur;
		case (dec_op)
			alu_pass: alu_res = op_b;
			alu_add, alu_sub: alu_res = add_sum[data_w-1:0];
			alu_addc: begin
				alu_res = add_sum[data_w-1:0];
				t_next  = add_sum[data_w];
			end
			alu_cmpeq: t_next = (op_a == op_b);
			alu_cmpgt: t_next = ($signed(op_a) > $signed(op_b));
			alu_and:   alu_res = op_a & op_b;
			alu_or:    alu_res = op_a | op_b;
			alu_xor:   alu_res = op_a ^ op_b;
			alu_tst:   t_next = ~|(op_a & op_b);
			alu_shll: begin
				alu_res = {op_a[data_w-2:0], 1'b0};
				t_next  = op_a[data_w-1];
			end
			alu_shlr: begin
				alu_res = {1'b0, op_a[data_w-1:1]};
				t_next  = op_a[0];
			end
			alu_rotl: begin
				alu_res = {op_a[data_w-2:0], op_a[data_w-1]};
				t_next  = op_a[data_w-1];
			end
			alu_rotr: begin
				alu_res = {op_a[0], op_a[data_w-1:1]};
				t_next  = op_a[0];
			end
			default: ;
		endcase
	end

	// ********************
	// Result register
	// ********************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex_valid <= 1'b0;
			ex_write <= 1'b0;
			ex_rn    <= '0;
			ex_data  <= '0;
			ex_t     <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
			ex_write <= dec_valid & dec_write;
			if (dec_valid) begin
				ex_rn <= dec_rn;
				ex_t  <= t_next;
			end
			// Data holds across non-writing instructions
			if (dec_valid && dec_write) begin
				ex_data <= alu_res;
			end
		end
	end

endmodule

// File: sh_regfile.sv
module sh_regfile import sh_pkg::*; (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic [reg_n_w-1:0] ra_n,
	input  logic [reg_n_w-1:0] rb_n,
	input  logic               we,
	input  logic [reg_n_w-1:0] wn,
	input  logic [data_w-1:0]  wd,
	output logic [data_w-1:0]  ra_q,
	output logic [data_w-1:0]  rb_q
);

	logic [data_w-1:0] regs [reg_cnt];

	// ********************
	// Write port
	// ********************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < reg_cnt; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wn] <= wd;
		end
	end

	// ********************
	// Read ports
	// ********************
	// No write-through here, execute forwards instead
	assign ra_q = regs[ra_n];
	assign rb_q = regs[rb_n];

endmodule

// File: sh_decode.sv
module sh_decode import sh_pkg::*; (
	input  logic               CLK,
	input  logic               RST_N,
	input  logic               instr_valid,
	input  logic [instr_w-1:0] instr,
	output logic               dec_valid,
	output alu_op_t            dec_op,
	output logic [reg_n_w-1:0] dec_rn,
	output logic [reg_n_w-1:0] dec_rm,
	output logic               dec_use_imm,
	output logic [data_w-1:0]  dec_imm,
	output logic               dec_write
);

	instr_u ir;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	// Word is only captured on a strobe
	always_ff @(posedge CLK) begin
		if (instr_valid) begin
			ir <= instr;
		end
	end

	assign dec_rn  = ir.rr_form.rn;
	assign dec_rm  = ir.rr_form.rm;
	assign dec_imm = {{(data_w - imm_w){ir.ri_form.imm[imm_w-1]}}, ir.ri_form.imm};

	assign dec_use_imm = (ir.ri_form.op == op_mov_imm) || (ir.ri_form.op == op_add_imm);

	// ********************
	// Opcode to ALU operation
	// ********************
	always_comb begin
		dec_op = alu_nop;
		case (ir.rr_form.op)
			op_mov_imm: dec_op = alu_pass;
			op_add_imm: dec_op = alu_add;
			op_arith: begin
				case (ir.rr_form.fn)
					fn_cmp_eq: dec_op = alu_cmpeq;
					fn_cmp_gt: dec_op = alu_cmpgt;
					fn_sub:    dec_op = alu_sub;
					fn_add:    dec_op = alu_add;
					fn_addc:   dec_op = alu_addc;
					default:   dec_op = alu_nop;
				endcase
			end
			op_logic: begin
				case (ir.rr_form.fn)
					fn_tst:  dec_op = alu_tst;
					fn_and:  dec_op = alu_and;
					fn_xor:  dec_op = alu_xor;
					fn_or:   dec_op = alu_or;
					default: dec_op = alu_nop;
				endcase
			end
			op_shift: begin
				if (ir.rr_form.rm == '0) begin
					case (ir.rr_form.fn)
						fn_shll: dec_op = alu_shll;
						fn_shlr: dec_op = alu_shlr;
						fn_rotl: dec_op = alu_rotl;
						fn_rotr: dec_op = alu_rotr;
						default: dec_op = alu_nop;
					endcase
				end
			end
			op_mov_reg: begin
				if (ir.rr_form.fn == mov_reg_fn) begin
					dec_op = alu_pass;
				end
			end
			default: dec_op = alu_nop;
		endcase
	end

	// Compares and test only touch T
	always_comb begin
		case (dec_op)
			alu_cmpeq, alu_cmpgt, alu_tst, alu_nop: dec_write = 1'b0;
			default:                                dec_write = 1'b1;
		endcase
	end

endmodule

// File: sh_pkg.sv
package sh_pkg;

	// ********************
	// Sizes
	// ********************
	localparam int data_w  = 32;
	localparam int instr_w = 16;
	localparam int reg_n_w = 4;
	localparam int reg_cnt = 16;
	localparam int imm_w   = 8;

	// ********************
	// Major opcodes, top nibble
	// ********************
	localparam logic [3:0] op_mov_imm = 4'b1110;
	localparam logic [3:0] op_add_imm = 4'b0111;
	localparam logic [3:0] op_arith   = 4'b0011;
	localparam logic [3:0] op_logic   = 4'b0010;
	localparam logic [3:0] op_shift   = 4'b0100;
	localparam logic [3:0] op_mov_reg = 4'b0110;

	// Arithmetic group
	localparam logic [3:0] fn_cmp_eq = 4'b0000;
	localparam logic [3:0] fn_cmp_gt = 4'b0111;
	localparam logic [3:0] fn_sub    = 4'b1000;
	localparam logic [3:0] fn_add    = 4'b1100;
	localparam logic [3:0] fn_addc   = 4'b1110;

	// Logic group
	localparam logic [3:0] fn_tst = 4'b1000;
	localparam logic [3:0] fn_and = 4'b1001;
	localparam logic [3:0] fn_xor = 4'b1010;
	localparam logic [3:0] fn_or  = 4'b1011;

	// Shift group, middle nibble must be zero
	localparam logic [3:0] fn_shll = 4'b0000;
	localparam logic [3:0] fn_shlr = 4'b0001;
	localparam logic [3:0] fn_rotl = 4'b0100;
	localparam logic [3:0] fn_rotr = 4'b0101;

	localparam logic [3:0] mov_reg_fn = 4'b0011;

	typedef enum logic [3:0] {
		alu_pass,
		alu_add,
		alu_addc,
		alu_sub,
		alu_cmpeq,
		alu_cmpgt,
		alu_and,
		alu_or,
		alu_xor,
		alu_tst,
		alu_shll,
		alu_shlr,
		alu_rotl,
		alu_rotr,
		alu_nop
	} alu_op_t;

	// Same word seen as register form or immediate form
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [3:0] rn;
			logic [3:0] rm;
			logic [3:0] fn;
		} rr_form;
		struct packed {
			logic [3:0]       op;
			logic [3:0]       rn;
			logic [imm_w-1:0] imm;
		} ri_form;
	} instr_u;

endpackage
